//--- scurve_pkg.sv
`default_nettype none

package scurve_pkg;

    //////////////////////////////
    // Field widths
    //////////////////////////////

    // Channels on the front-end ASIC
    localparam int NUM_CHN = 64;

    // Threshold DAC resolution
    localparam int DAC_W = 10;
    // Enough bits to index every channel
    localparam int CHN_W = $clog2(NUM_CHN);
    // Trigger counts and window length
    localparam int COUNT_W = 16;
    // USB data path word
    localparam int USB_W = 16;

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [DAC_W-1:0]   dac_code_t;
    typedef logic [CHN_W-1:0]   chn_idx_t;
    // One-hot Ctest injection select
    typedef logic [NUM_CHN-1:0] chn_mask_t;
    // Also the type of the window length, so a count cannot overflow
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [USB_W-1:0]   usb_word_t;

    // One point of the sweep, laid out as the header word
    typedef struct packed {
        chn_idx_t  channel;
        dac_code_t dac;
    } scan_step_t;

    //////////////////////////////
    // State machines
    //////////////////////////////

    typedef enum logic [2:0] {
        seq_idle, seq_load, seq_wait_cfg, seq_count, seq_drain, seq_next, seq_done
    } seq_state_t;

    typedef enum logic {
        pk_idle, pk_send
    } pack_state_t;

endpackage

`default_nettype wire

//--- scurve_ext_window.sv
`default_nettype none

module scurve_ext_window
    import scurve_pkg::*;
(
    input  wire         Clk,
    input  wire         reset_n,
    input  wire         clk_ext,
    input  wire         arm,
    input  wire count_t cpt_max,
    output logic        open,
    output logic        closed
);

    // Synchroniser stages plus one stage for edge detection
    logic   clk_s1;
    logic   clk_s2;
    logic   clk_s3;
    logic   rise;
    // Waiting for the first edge after arm
    logic   armed;
    // Edges seen since the window opened
    count_t edge_cnt;
    logic   last_edge;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            clk_s1 <= 1'b0;
            clk_s2 <= 1'b0;
            clk_s3 <= 1'b0;
        end else begin
            clk_s1 <= clk_ext;
            clk_s2 <= clk_s1;
            clk_s3 <= clk_s2;
        end
    end

    // Synchronised rising edge of the external clock
    assign rise = clk_s2 & ~clk_s3;
    // The next edge is the cpt_max-th one after opening
    assign last_edge = (edge_cnt == cpt_max - count_t'(1));
    // Close strobe in the same cycle as the final edge
    assign closed = open & rise & last_edge;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            armed    <= 1'b0;
            open     <= 1'b0;
            edge_cnt <= '0;
        end else if (arm) begin
            // New step, drop any window still running
            armed    <= 1'b1;
            open     <= 1'b0;
            edge_cnt <= '0;
        end else if (armed && rise) begin
            armed    <= 1'b0;
            open     <= 1'b1;
            edge_cnt <= '0;
        end else if (open && rise) begin
            if (last_edge) begin
                open <= 1'b0;
            end else begin
                edge_cnt <= edge_cnt + count_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- scurve_trig_counter.sv
`default_nettype none

module scurve_trig_counter
    import scurve_pkg::*;
(
    input  wire    Clk,
    input  wire    reset_n,
    // Active-low discriminator output, asynchronous to Clk
    input  wire    trig_b,
    input  wire    arm,
    input  wire    open,
    output count_t count
);

    //////////////////////////////
    // Input synchroniser
    //////////////////////////////

    logic trig_s1;
    logic trig_s2;
    // Previous synchronised level
    logic trig_s3;
    logic fall;

    // Idle level of the trigger is high
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            trig_s1 <= 1'b1;
            trig_s2 <= 1'b1;
            trig_s3 <= 1'b1;
        end else begin
            trig_s1 <= trig_b;
            trig_s2 <= trig_s1;
            trig_s3 <= trig_s2;
        end
    end

    // High to low on the synchronised line
    assign fall = trig_s3 & ~trig_s2;

    //////////////////////////////
    // Edge counter
    //////////////////////////////

    // Cleared by arm, held after the window closes
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (arm) begin
            count <= '0;
        end else if (open && fall) begin
            count <= count + count_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- scurve_sequencer.sv
`default_nettype none

module scurve_sequencer
    import scurve_pkg::*;
(
    input  wire            Clk,
    input  wire            reset_n,
    input  wire            test_start,
    input  wire chn_idx_t  single_chn,
    input  wire            single_mode,
    input  wire            ctest_inject,
    input  wire dac_code_t dac_first,
    input  wire dac_code_t dac_last,
    input  wire            config_done,
    input  wire            closed,
    input  wire            busy,
    output logic           sc_param_load,
    output chn_mask_t      ctest_mask,
    output dac_code_t      dac_out,
    output logic           arm,
    output logic           capture,
    output scan_step_t     step,
    output logic           test_done
);

    seq_state_t state;

    // Start edge detection
    logic start_q1;
    logic start_q2;
    logic start_pulse;

    // Scan settings frozen at start
    logic      mode_single_q;
    logic      inject_q;
    dac_code_t dac_first_q;
    dac_code_t dac_last_q;

    // Current sweep point
    chn_idx_t  chn_q;
    dac_code_t dac_q;
    // Step in flight is the final one
    logic      last_q;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            start_q1 <= 1'b0;
            start_q2 <= 1'b0;
        end else begin
            start_q1 <= test_start;
            start_q2 <= start_q1;
        end
    end

    assign start_pulse = start_q1 & ~start_q2;

    //////////////////////////////
    // Outputs to ASIC and packer
    //////////////////////////////

    // Load strobe is the single cycle spent in seq_load
    assign sc_param_load = (state == seq_load);
    // No injection mask when a single channel is driven from its input pin
    assign ctest_mask = (mode_single_q && !inject_q) ? '0 : chn_mask_t'(1) << chn_q;
    assign dac_out = dac_q;
    assign step = '{channel: chn_q, dac: dac_q};

    //////////////////////////////
    // Scan FSM
    //////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= seq_idle;
            arm           <= 1'b0;
            capture       <= 1'b0;
            test_done     <= 1'b0;
            last_q        <= 1'b0;
            mode_single_q <= 1'b0;
            inject_q      <= 1'b0;
            dac_first_q   <= '0;
            dac_last_q    <= '0;
            chn_q         <= '0;
            dac_q         <= '0;
        end else begin
            // Strobes default low
            arm     <= 1'b0;
            capture <= 1'b0;
            case (state)
                seq_idle, seq_done: begin
                    if (start_pulse) begin
                        mode_single_q <= single_mode;
                        inject_q      <= ctest_inject;
                        dac_first_q   <= dac_first;
                        dac_last_q    <= dac_last;
                        chn_q         <= single_mode ? single_chn : '0;
                        dac_q         <= dac_first;
                        last_q        <= 1'b0;
                        test_done     <= 1'b0;
                        state         <= seq_load;
                    end
                end
                seq_load: begin
                    state <= seq_wait_cfg;
                end
                seq_wait_cfg: begin
                    if (config_done) begin
                        arm   <= 1'b1;
                        state <= seq_count;
                    end
                end
                seq_count: begin
                    if (closed) begin
                        capture <= 1'b1;
                        state   <= seq_next;
                    end
                end
                seq_next: begin
                    // Packer samples the old step on this same edge
                    if (dac_q >= dac_last_q) begin
                        if (mode_single_q || chn_q == chn_idx_t'(NUM_CHN - 1)) begin
                            last_q <= 1'b1;
                        end else begin
                            chn_q <= chn_q + chn_idx_t'(1);
                            dac_q <= dac_first_q;
                        end
                    end else begin
                        dac_q <= dac_q + dac_code_t'(1);
                    end
                    state <= seq_drain;
                end
                seq_drain: begin
                    // Busy drops with the last word of the step
                    if (!busy) begin
                        test_done <= last_q;
                        state     <= last_q ? seq_done : seq_load;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- scurve_packer.sv
`default_nettype none

module scurve_packer
    import scurve_pkg::*;
#(
    parameter int NUM_TRIG    = 3,
    parameter int USB_CREDITS = 4
) (
    input  wire                         Clk,
    input  wire                         reset_n,
    input  wire                         capture,
    input  wire scan_step_t             step,
    input  wire count_t [NUM_TRIG-1:0]  counts,
    input  wire                         usb_credit,
    output logic                        busy,
    output logic                        usb_wr_en,
    output usb_word_t                   usb_data
);

    // Credit counter must hold the full buffer depth
    localparam int CRD_W = $clog2(USB_CREDITS + 1);
    // Header plus one word per trigger
    localparam int IDX_W = $clog2(NUM_TRIG + 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_TRIG);

    pack_state_t           state;
    scan_step_t            step_q;
    count_t [NUM_TRIG-1:0] counts_q;
    logic [IDX_W-1:0]      word_idx;
    logic [CRD_W-1:0]      credits;
    logic                  last_word;

    //////////////////////////////
    // Output words
    //////////////////////////////

    // A word goes out whenever one is pending and the consumer has room
    assign usb_wr_en = (state == pk_send) && (credits != '0);
    assign last_word = usb_wr_en && (word_idx == LAST_IDX);
    // Released in the cycle of the final word
    assign busy = (state == pk_send) && !last_word;

    always_comb begin
        if (word_idx == '0) begin
            usb_data = usb_word_t'(step_q);
        end else begin
            usb_data = usb_word_t'(counts_q[word_idx - IDX_W'(1)]);
        end
    end

    // Snapshot of the finished step
    always_ff @(posedge Clk) begin
        if (capture && state == pk_idle) begin
            step_q   <= step;
            counts_q <= counts;
        end
    end

    //////////////////////////////
    // Send FSM and credits
    //////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= pk_idle;
            word_idx <= '0;
        end else begin
            case (state)
                pk_idle: begin
                    if (capture) begin
                        word_idx <= '0;
                        state    <= pk_send;
                    end
                end
                pk_send: begin
                    if (usb_wr_en) begin
                        if (word_idx == LAST_IDX) begin
                            state <= pk_idle;
                        end else begin
                            word_idx <= word_idx + IDX_W'(1);
                        end
                    end
                end
                default: begin
                    state <= pk_idle;
                end
            endcase
        end
    end

    // Return and spend in one cycle cancel out
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            credits <= CRD_W'(USB_CREDITS);
        end else begin
            case ({usb_credit, usb_wr_en})
                2'b10:   credits <= credits + CRD_W'(1);
                2'b01:   credits <= credits - CRD_W'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- scurve_test_top.sv
`default_nettype none

module scurve_test_top
    import scurve_pkg::*;
#(
    parameter int NUM_TRIG    = 3,
    parameter int USB_CREDITS = 4
) (
    input  wire                Clk,
    input  wire                reset_n,
    // Scan control
    input  wire                test_start,
    input  wire chn_idx_t      single_chn,
    input  wire                single_mode,
    input  wire                ctest_inject,
    input  wire dac_code_t     dac_first,
    input  wire dac_code_t     dac_last,
    input  wire count_t        cpt_max,
    // ASIC slow control
    input  wire                config_done,
    output logic               sc_param_load,
    output chn_mask_t          ctest_mask,
    output dac_code_t          dac_out,
    // ASIC pins
    input  wire                clk_ext,
    input  wire [NUM_TRIG-1:0] trig_b,
    // USB data path
    input  wire                usb_credit,
    output logic               usb_wr_en,
    output usb_word_t          usb_data,
    output logic               test_done
);

    logic                  arm;
    logic                  open;
    logic                  closed;
    logic                  capture;
    logic                  busy;
    scan_step_t            step;
    count_t [NUM_TRIG-1:0] counts;

    scurve_sequencer i_sequencer (
        .Clk           (Clk),
        .reset_n       (reset_n),
        .test_start    (test_start),
        .single_chn    (single_chn),
        .single_mode   (single_mode),
        .ctest_inject  (ctest_inject),
        .dac_first     (dac_first),
        .dac_last      (dac_last),
        .config_done   (config_done),
        .closed        (closed),
        .busy          (busy),
        .sc_param_load (sc_param_load),
        .ctest_mask    (ctest_mask),
        .dac_out       (dac_out),
        .arm           (arm),
        .capture       (capture),
        .step          (step),
        .test_done     (test_done)
    );

    // Counting window shared by all triggers
    scurve_ext_window i_window (
        .Clk     (Clk),
        .reset_n (reset_n),
        .clk_ext (clk_ext),
        .arm     (arm),
        .cpt_max (cpt_max),
        .open    (open),
        .closed  (closed)
    );

    // One counter per discriminator
    for (genvar g = 0; g < NUM_TRIG; g++) begin : g_trig
        scurve_trig_counter i_trig_counter (
            .Clk     (Clk),
            .reset_n (reset_n),
            .trig_b  (trig_b[g]),
            .arm     (arm),
            .open    (open),
            .count   (counts[g])
        );
    end

    scurve_packer #(
        .NUM_TRIG    (NUM_TRIG),
        .USB_CREDITS (USB_CREDITS)
    ) i_packer (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .capture    (capture),
        .step       (step),
        .counts     (counts),
        .usb_credit (usb_credit),
        .busy       (busy),
        .usb_wr_en  (usb_wr_en),
        .usb_data   (usb_data)
    );

endmodule

`default_nettype wire

//--- scurve_sva.sv
`default_nettype none

module scurve_sva
    import scurve_pkg::*;
#(
    parameter int USB_CREDITS = 4
) (
    input wire            Clk,
    input wire            reset_n,
    input wire            usb_wr_en,
    input wire            usb_credit,
    input wire usb_word_t usb_data,
    input wire            sc_param_load,
    input wire            config_done
);

    timeunit 1ns;
    timeprecision 1ps;

    // Credits left, counted from the bus strobes alone
    int   credits_left;
    // Load issued and not yet answered by the ASIC
    logic load_pending;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            credits_left <= USB_CREDITS;
        end else begin
            credits_left <= credits_left + int'(usb_credit) - int'(usb_wr_en);
        end
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            load_pending <= 1'b0;
        end else if (sc_param_load) begin
            load_pending <= 1'b1;
        end else if (config_done) begin
            load_pending <= 1'b0;
        end
    end

    // No write into a full consumer buffer
    a_credit_avail: assert property (@(posedge Clk) disable iff (!reset_n)
        usb_wr_en |-> credits_left > 0)
        else $error("usb_wr_en asserted with zero credits");

    // Slow control sees exactly one single-cycle load strobe per step
    a_load_pulse: assert property (@(posedge Clk) disable iff (!reset_n)
        sc_param_load |-> !load_pending)
        else $error("sc_param_load held or repeated before config_done");

    // Words on the bus are fully driven
    a_data_known: assert property (@(posedge Clk) disable iff (!reset_n)
        usb_wr_en |-> !$isunknown(usb_data))
        else $error("usb_data has unknown bits during usb_wr_en");

endmodule

bind scurve_packer scurve_sva #(
    .USB_CREDITS (USB_CREDITS)
) i_sva (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .usb_wr_en     (usb_wr_en),
    .usb_credit    (usb_credit),
    .usb_data      (usb_data),
    .sc_param_load (1'b0),
    .config_done   (1'b0)
);

// Sequencer side only carries the load handshake
bind scurve_sequencer scurve_sva i_sva (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .usb_wr_en     (1'b0),
    .usb_credit    (1'b0),
    .usb_data      ('0),
    .sc_param_load (sc_param_load),
    .config_done   (config_done)
);

`default_nettype wire

//--- scurve_tb.sv
`default_nettype none

module scurve_tb
    import scurve_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_TRIG     = 3;
    localparam int          USB_CREDITS  = 4;
    localparam logic [31:0] SEED         = 32'h367e26d5;
    localparam int          LOAD_TIMEOUT = 3000;

    logic                Clk;
    logic                reset_n;
    logic                test_start;
    chn_idx_t            single_chn;
    logic                single_mode;
    logic                ctest_inject;
    dac_code_t           dac_first;
    dac_code_t           dac_last;
    count_t              cpt_max;
    logic                config_done;
    logic                sc_param_load;
    chn_mask_t           ctest_mask;
    dac_code_t           dac_out;
    logic                clk_ext = 1'b0;
    logic [NUM_TRIG-1:0] trig_b;
    logic                usb_credit = 1'b0;
    logic                usb_wr_en;
    usb_word_t           usb_data;
    logic                test_done;

    // Position inside the external clock period, 0 is the rising edge
    logic [2:0]  ext_phase = 3'd0;
    // One generator per process keeps draws independent of process order
    logic [31:0] main_lfsr = SEED;
    logic [31:0] asic_lfsr = SEED;
    logic [31:0] usb_lfsr  = SEED;
    // Expected loads and expected USB stream of the current scan
    scan_step_t  load_steps[$];
    usb_word_t   exp_words[$];
    int          delay_q[$];
    logic        cur_single  = 1'b0;
    logic        cur_inject  = 1'b0;
    count_t      cur_cpt     = count_t'(4);
    int          credit_bits = 2;
    int          word_pos    = 0;
    int          outstanding = 0;
    int          crd_cnt     = 0;
    logic        crd_busy    = 1'b0;
    int          errors      = 0;

    scurve_test_top i_dut (.*);

    //////////////////////////////
    // Random source and reference
    //////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            st  = lfsr_step(st);
            val = (val << 1) | int'(st[0]);
        end
    endtask

    // Discriminator k fires in period i of this step
    function automatic logic trig_fires(input chn_idx_t ch, input dac_code_t dac,
                                        input int k, input int i);
        return ((i * 37 + int'(ch) * 11 + k * 53) % 256) < (int'(dac) / 4);
    endfunction

    function automatic count_t ref_count(input chn_idx_t ch, input dac_code_t dac,
                                         input int k, input count_t cpt);
        int n;
        n = 0;
        for (int i = 0; i < int'(cpt); i++) begin
            if (trig_fires(ch, dac, k, i)) begin
                n++;
            end
        end
        return count_t'(n);
    endfunction

    // Loads in sweep order, then header and counts per step
    task automatic build_expected(input logic single, input chn_idx_t chn,
                                  input dac_code_t first, input dac_code_t last,
                                  input count_t cpt);
        int c_lo;
        int c_hi;
        c_lo = single ? int'(chn) : 0;
        c_hi = single ? int'(chn) : NUM_CHN - 1;
        for (int c = c_lo; c <= c_hi; c++) begin
            for (int d = int'(first); d <= int'(last); d++) begin
                load_steps.push_back('{channel: chn_idx_t'(c), dac: dac_code_t'(d)});
                exp_words.push_back(usb_word_t'({chn_idx_t'(c), dac_code_t'(d)}));
                for (int k = 0; k < NUM_TRIG; k++) begin
                    exp_words.push_back(usb_word_t'(ref_count(chn_idx_t'(c), dac_code_t'(d),
                                                              k, cpt)));
                end
            end
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic fail_run();
        errors++;
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_step(input scan_step_t got, input scan_step_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: header ch %0d dac %0d, expected ch %0d dac %0d",
                     $time, got.channel, got.dac, exp.channel, exp.dac);
            fail_run();
        end
    endtask

    task automatic compare_count(input count_t got, input count_t exp, input int k);
        if (got !== exp) begin
            $display("[ERROR] %0t: trigger %0d count %0d, expected %0d", $time, k, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_mask(input chn_mask_t got, input chn_mask_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: ctest_mask %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_dac(input dac_code_t got, input dac_code_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: dac_out %0d, expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    //////////////////////////////
    // Clock and ASIC model
    //////////////////////////////

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    // clk_ext is 8 Clk cycles, high for the first half
    always @(posedge Clk) begin : ext_clock
        logic [2:0] next_phase;
        next_phase = ext_phase + 3'd1;
        ext_phase <= next_phase;
        clk_ext   <= (next_phase < 3'd4);
    end

    task automatic wait_phase(input logic [2:0] p);
        int n;
        n = 0;
        do begin
            @(posedge Clk);
            n++;
        end while (ext_phase != p && n < 16);
        if (ext_phase != p) begin
            $display("The clk_ext phase %0d was not reached within 16 cycles", p);
            fail_run();
        end
    endtask

    // Answers each load, then plays the trigger pattern of the step
    initial begin : asic_model
        scan_step_t          st;
        chn_mask_t           exp_mask;
        logic [NUM_TRIG-1:0] fire;
        int                  dly;
        int                  waited;
        config_done = 1'b0;
        trig_b      = '1;
        forever begin
            waited = 0;
            do begin
                @(posedge Clk);
                waited++;
            end while (sc_param_load !== 1'b1 && waited < LOAD_TIMEOUT);
            if (sc_param_load !== 1'b1) begin
                $display("No sc_param_load came within %0d cycles", LOAD_TIMEOUT);
                fail_run();
            end
            if (load_steps.size() == 0) begin
                $display("The DUT issued sc_param_load after the last step of the scan");
                fail_run();
            end
            st       = load_steps.pop_front();
            // Pin input in single mode leaves the mask empty
            exp_mask = '0;
            if (!cur_single || cur_inject) begin
                exp_mask[st.channel] = 1'b1;
            end
            compare_mask(ctest_mask, exp_mask);
            compare_dac(dac_out, st.dac);
            draw_bits(asic_lfsr, 4, dly);
            repeat (dly) @(posedge Clk);
            // Mid period, so the next rising edge starts period 0
            wait_phase(3'd3);
            config_done <= 1'b1;
            @(posedge Clk);
            config_done <= 1'b0;
            for (int i = 0; i < int'(cur_cpt); i++) begin
                for (int k = 0; k < NUM_TRIG; k++) begin
                    fire[k] = trig_fires(st.channel, st.dac, k, i);
                end
                wait_phase(3'd3);
                trig_b <= ~fire;
                repeat (3) @(posedge Clk);
                trig_b <= '1;
            end
        end
    end

    //////////////////////////////
    // USB consumer and compare
    //////////////////////////////

    always @(posedge Clk) begin : usb_model
        usb_word_t exp_w;
        int        dly;
        usb_credit <= 1'b0;
        if (reset_n) begin
            if (usb_wr_en) begin
                if (exp_words.size() == 0) begin
                    $display("The DUT wrote a USB word that the scan does not produce");
                    fail_run();
                end
                exp_w = exp_words.pop_front();
                if (word_pos == 0) begin
                    compare_step(scan_step_t'(usb_data), scan_step_t'(exp_w));
                end else begin
                    compare_count(count_t'(usb_data), count_t'(exp_w), word_pos - 1);
                end
                word_pos = (word_pos == NUM_TRIG) ? 0 : word_pos + 1;
                draw_bits(usb_lfsr, credit_bits, dly);
                delay_q.push_back(dly);
                outstanding++;
                if (outstanding > USB_CREDITS) begin
                    $display("[ERROR] %0t: %0d words outstanding, buffer holds %0d",
                             $time, outstanding, USB_CREDITS);
                    fail_run();
                end
            end
            // One credit back per word, in order
            if (crd_busy) begin
                if (crd_cnt == 0) begin
                    usb_credit <= 1'b1;
                    outstanding--;
                    crd_busy = 1'b0;
                end else begin
                    crd_cnt--;
                end
            end else if (delay_q.size() > 0) begin
                crd_cnt  = delay_q.pop_front();
                crd_busy = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Scenarios
    //////////////////////////////

    task automatic run_scan(input logic single, input logic inject, input chn_idx_t chn,
                            input dac_code_t first, input dac_code_t last,
                            input count_t cpt, input int crd_bits);
        int   n;
        int   limit;
        logic was_done;
        cur_single  = single;
        cur_inject  = inject;
        cur_cpt     = cpt;
        credit_bits = crd_bits;
        build_expected(single, chn, first, last, cpt);
        limit    = load_steps.size() * 600 + 200;
        was_done = test_done;
        @(posedge Clk);
        single_mode  <= single;
        ctest_inject <= inject;
        single_chn   <= chn;
        dac_first    <= first;
        dac_last     <= last;
        cpt_max      <= cpt;
        test_start   <= 1'b1;
        // Done flag of the previous scan drops on the new start edge
        if (was_done) begin
            n = 0;
            do begin
                @(posedge Clk);
                n++;
            end while (test_done !== 1'b0 && n < 8);
            if (test_done !== 1'b0) begin
                $display("test_done stayed high after a new test_start edge");
                fail_run();
            end
        end
        repeat (3) @(posedge Clk);
        test_start <= 1'b0;
        n = 0;
        do begin
            @(posedge Clk);
            n++;
        end while (test_done !== 1'b1 && n < limit);
        if (test_done !== 1'b1) begin
            $display("The scan did not finish within %0d cycles", limit);
            fail_run();
        end
        if (exp_words.size() != 0 || load_steps.size() != 0) begin
            $display("[ERROR] %0t: test_done with %0d words and %0d loads still expected",
                     $time, exp_words.size(), load_steps.size());
            fail_run();
        end
    endtask

    initial begin : main_seq
        int chn;
        int code;
        int cpt;
        reset_n      = 1'b0;
        test_start   = 1'b0;
        single_chn   = '0;
        single_mode  = 1'b0;
        ctest_inject = 1'b0;
        dac_first    = '0;
        dac_last     = '0;
        cpt_max      = count_t'(4);
        repeat (2) @(posedge Clk);
        reset_n <= 1'b1;
        repeat (3) @(posedge Clk);

        // Single channel through Ctest
        draw_bits(main_lfsr, 6, chn);
        draw_bits(main_lfsr, 9, code);
        draw_bits(main_lfsr, 3, cpt);
        run_scan(1'b1, 1'b1, chn_idx_t'(chn), dac_code_t'(200 + code),
                 dac_code_t'(203 + code), count_t'(4 + cpt), 2);

        // Single channel through the input pin
        draw_bits(main_lfsr, 6, chn);
        draw_bits(main_lfsr, 9, code);
        draw_bits(main_lfsr, 3, cpt);
        run_scan(1'b1, 1'b0, chn_idx_t'(chn), dac_code_t'(200 + code),
                 dac_code_t'(203 + code), count_t'(4 + cpt), 2);

        // High thresholds, dense trigger counts
        draw_bits(main_lfsr, 6, chn);
        draw_bits(main_lfsr, 7, code);
        draw_bits(main_lfsr, 3, cpt);
        run_scan(1'b1, 1'b1, chn_idx_t'(chn), dac_code_t'(600 + code),
                 dac_code_t'(605 + code), count_t'(4 + cpt), 2);

        // Full sweep of 64 channels, two codes each
        draw_bits(main_lfsr, 3, cpt);
        run_scan(1'b0, 1'b0, chn_idx_t'(0), dac_code_t'(800), dac_code_t'(801),
                 count_t'(4 + cpt), 1);

        // Slow consumer
        draw_bits(main_lfsr, 6, chn);
        draw_bits(main_lfsr, 9, code);
        draw_bits(main_lfsr, 3, cpt);
        run_scan(1'b1, 1'b1, chn_idx_t'(chn), dac_code_t'(300 + code),
                 dac_code_t'(303 + code), count_t'(4 + cpt), 5);

        repeat (4) @(posedge Clk);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
scurve_pkg.sv
scurve_ext_window.sv
scurve_trig_counter.sv
scurve_sequencer.sv
scurve_packer.sv
scurve_test_top.sv
scurve_sva.sv
scurve_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= scurve_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
